/* hdl/fir_consts.svh */
//**************************************************************************
// FIR filter constants
// widths, tap counts, pipeline latency and the coefficient table
//**************************************************************************

`ifndef FIR_CONSTS_SVH
`define FIR_CONSTS_SVH

// sample, sum and product width
`define FIR_DATA_W 18

// taps of the symmetric filter and its unique half, centre tap included
`define FIR_NUM_TAPS 33
`define FIR_NUM_UNIQ ((`FIR_NUM_TAPS + 1) / 2)

// registered levels of the adder tree
`define FIR_TREE_LEVELS $clog2(`FIR_NUM_UNIQ)

// tap reg + pre-add reg + multiply reg + tree levels
`define FIR_LATENCY (3 + `FIR_TREE_LEVELS)

// unique coefficients, index 0 first (outer taps)
`define FIR_COEFF_TABLE '{ \
	18'sd88,   18'sd0,    -18'sd97,  -18'sd197, \
	-18'sd294, -18'sd380, -18'sd447, -18'sd490, \
	-18'sd504, -18'sd481, -18'sd420, -18'sd319, \
	-18'sd178, 18'sd0,    18'sd212,  18'sd451,  \
	18'sd710 \
}

`endif

/* hdl/fir_pkg.sv */
//**************************************************************************
// FIR filter package
// sample type and the tap / unique-term vector types
//**************************************************************************

`include "fir_consts.svh"

package fir_pkg;

	// one sample, sum or product; arithmetic wraps modulo 2^18
	typedef logic [`FIR_DATA_W-1:0] sample_t;

	// whole delay line, element 0 is the newest sample
	typedef sample_t [`FIR_NUM_TAPS-1:0] tap_vec_t;

	// folded pairs and their products, element 16 is the centre tap
	typedef sample_t [`FIR_NUM_UNIQ-1:0] uniq_vec_t;

endpackage

/* hdl/tap_delay_line.sv */
//**************************************************************************
// tap delay line
// shift register of the last 33 input samples, cleared by reset
//**************************************************************************

`timescale 1ns/1ps

`include "fir_consts.svh"

module tap_delay_line
	import fir_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     i_clk_ena,
	input  sample_t  i_in,
	output tap_vec_t o_taps
);

	// tap 0 takes the new sample, tap 32 holds the oldest
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_taps <= '0;
		end else if (i_clk_ena) begin
			o_taps <= {o_taps[`FIR_NUM_TAPS-2:0], i_in};
		end
	end

	//**********************************************************************
	// checks
	//**********************************************************************

	// an unknown enable would corrupt every stage of the pipeline at once
	a_clk_ena_known : assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(i_clk_ena)
	) else $error("tap_delay_line: i_clk_ena is unknown");

endmodule

/* hdl/symmetric_preadder.sv */
//**************************************************************************
// symmetric pre-adder
// folds mirrored taps into 16 registered sums plus the centre tap
//**************************************************************************

`timescale 1ns/1ps

`include "fir_consts.svh"

module symmetric_preadder
	import fir_pkg::*;
(
	input  logic      clk,
	input  logic      i_clk_ena,
	input  tap_vec_t  i_taps,
	output uniq_vec_t o_folded
);

	localparam int CENTRE = `FIR_NUM_UNIQ - 1;

	// tap k and tap 32-k share a coefficient, so add them first
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < CENTRE; k++) begin
				o_folded[k] <= i_taps[k] + i_taps[`FIR_NUM_TAPS-1-k];
			end
			// centre tap has no partner
			o_folded[CENTRE] <= i_taps[CENTRE];
		end
	end

endmodule

/* hdl/coeff_multiplier.sv */
//**************************************************************************
// coefficient multiplier
// registered products of the folded sums with the fixed coefficients
//**************************************************************************

`timescale 1ns/1ps

`include "fir_consts.svh"

module coeff_multiplier
	import fir_pkg::*;
(
	input  logic      clk,
	input  logic      i_clk_ena,
	input  uniq_vec_t i_folded,
	output uniq_vec_t o_products
);

	// index 0 pairs with the outermost taps, index 16 with the centre
	localparam sample_t COEFF [`FIR_NUM_UNIQ] = `FIR_COEFF_TABLE;

	// low 18 bits of the product are the same for signed and unsigned
	// operands, so a plain multiply keeps two's complement wraparound
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < `FIR_NUM_UNIQ; k++) begin
				o_products[k] <= i_folded[k] * COEFF[k];
			end
		end
	end

endmodule

/* hdl/adder_tree.sv */
//**************************************************************************
// registered adder tree
// sums pairs level by level; an odd leftover term rides a bye register
//**************************************************************************

`timescale 1ns/1ps

`include "fir_consts.svh"

module adder_tree
	import fir_pkg::*;
#(
	// terms summed from the low end of i_terms, at most FIR_NUM_UNIQ
	parameter int NUM_INPUTS = `FIR_NUM_UNIQ
) (
	input  logic      clk,
	input  logic      i_clk_ena,
	input  uniq_vec_t i_terms,
	output sample_t   o_sum
);

	// one register level per halving
	localparam int LEVELS = $clog2(NUM_INPUTS);

	// terms present after a given number of levels
	function automatic int terms_at(input int level);
		int n;
		n = NUM_INPUTS;
		for (int i = 0; i < level; i++) begin
			n = (n + 1) / 2;
		end
		return n;
	endfunction

	//**********************************************************************
	// levels
	//**********************************************************************

	// 17 -> 9 -> 5 -> 3 -> 2 -> 1 for the default count
	for (genvar l = 0; l <= LEVELS; l++) begin : g_level
		localparam int N_OUT = terms_at(l);

		sample_t [N_OUT-1:0] q;

		if (l == 0) begin : g_inputs
			assign q = i_terms[N_OUT-1:0];
		end else begin : g_stage
			localparam int N_IN = terms_at(l - 1);

			always_ff @(posedge clk) begin
				if (i_clk_ena) begin
					for (int t = 0; t < N_IN / 2; t++) begin
						q[t] <= g_level[l-1].q[2*t] + g_level[l-1].q[2*t+1];
					end
					// bye for the odd term out
					if (N_IN % 2 == 1) begin
						q[N_OUT-1] <= g_level[l-1].q[N_IN-1];
					end
				end
			end
		end
	end

	assign o_sum = g_level[LEVELS].q[0];

endmodule

/* hdl/valid_delay.sv */
//**************************************************************************
// valid delay
// carries i_valid through as many enabled stages as the data path
//**************************************************************************

`timescale 1ns/1ps

`include "fir_consts.svh"

module valid_delay (
	input  logic clk,
	input  logic reset,
	input  logic i_clk_ena,
	input  logic i_valid,
	output logic o_valid
);

	localparam int DEPTH = `FIR_LATENCY;

	logic [DEPTH-1:0] valid_pipe;

	// moves only with the data, so stalls keep the two aligned
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
		end else if (i_clk_ena) begin
			valid_pipe <= {valid_pipe[DEPTH-2:0], i_valid};
		end
	end

	assign o_valid = valid_pipe[DEPTH-1];

	// no output may be flagged while the pipeline is held in reset
	a_no_valid_in_reset : assert property (
		@(posedge clk) reset |-> !o_valid
	) else $error("valid_delay: o_valid high during reset");

endmodule

/* hdl/fir_top.sv */
//**************************************************************************
// 33-tap symmetric FIR filter
// delay line, folding pre-adder, multipliers and adder tree, with the
// valid flag delayed alongside; i_clk_ena freezes the whole pipeline
//**************************************************************************

`timescale 1ns/1ps

module fir_top
	import fir_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    i_clk_ena,
	input  logic    i_valid,
	input  sample_t i_in,
	output logic    o_valid,
	output sample_t o_out
);

	tap_vec_t  taps;
	uniq_vec_t folded;
	uniq_vec_t products;

	//**********************************************************************
	// data path
	//**********************************************************************

	// sample enters on every enabled edge, valid or not
	tap_delay_line u_taps (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_in      (i_in),
		.o_taps    (taps)
	);

	symmetric_preadder u_preadd (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_taps    (taps),
		.o_folded  (folded)
	);

	coeff_multiplier u_mult (
		.clk        (clk),
		.i_clk_ena  (i_clk_ena),
		.i_folded   (folded),
		.o_products (products)
	);

	// 17 terms in, 5 registered levels
	adder_tree u_tree (
		.clk       (clk),
		.i_clk_ena (i_clk_ena),
		.i_terms   (products),
		.o_sum     (o_out)
	);

	//**********************************************************************
	// valid alignment
	//**********************************************************************

	valid_delay u_valid (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.o_valid   (o_valid)
	);

endmodule

/* bench/fir_tb_tasks.svh */
//**************************************************************************
// FIR testbench tasks
// stimulus, value check, output draining and the directed tests
//**************************************************************************

`ifndef FIR_TB_TASKS_SVH
`define FIR_TB_TASKS_SVH

task automatic compare_values(input string what, input logic [31:0] expected,
	input logic [31:0] actual);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("** Error [%s] %s: expected 'h%0h, actual 'h%0h",
			test_name, what, expected, actual);
	end
endtask

function automatic sample_t random_sample();
	int r;
	r = $random(seed);
	return r[`FIR_DATA_W-1:0];
endfunction

function automatic logic random_bit();
	int r;
	r = $random(seed);
	return r[0];
endfunction

// new inputs 1 ns after the edge, taken at the next one
task automatic drive_cycle(input logic ena, input logic valid, input sample_t data);
	@(posedge clk);
	#1;
	i_clk_ena = ena;
	i_valid = valid;
	i_in = data;
endtask

task automatic apply_reset();
	@(posedge clk);
	#1;
	reset = 1'b1;
	i_clk_ena = 1'b1;
	i_valid = 1'b1;
	i_in = '0;
	repeat (10) @(posedge clk);
	#1;
	reset = 1'b0;
	i_clk_ena = 1'b0;
	i_valid = 1'b0;
endtask

task automatic start_test(input string name);
	test_name = name;
	seen_base = valid_seen;
	got_base = got_y.size();
	$display("running %s", name);
endtask

// clock invalid samples through until target valid outputs have arrived
task automatic drain_outputs(input int target);
	int cycles;
	cycles = 0;
	while (valid_seen - seen_base < target && cycles < DRAIN_TIMEOUT) begin
		drive_cycle(1'b1, 1'b0, '0);
		cycles++;
	end
	if (valid_seen - seen_base < target) begin
		errors++;
		$display("[%s] timed out after %0d cycles: %0d of %0d valid outputs arrived",
			test_name, cycles, valid_seen - seen_base, target);
	end
	// any extra valid output would show up within one latency
	repeat (`FIR_LATENCY + 2) drive_cycle(1'b1, 1'b0, '0);
	compare_values("valid output count", target, valid_seen - seen_base);
endtask

//**************************************************************************
// directed tests
//**************************************************************************

task automatic test_reset();
	sample_t x0;
	longint  prod;
	start_test("reset");
	apply_reset();
	x0 = random_sample();
	drive_cycle(1'b1, 1'b1, x0);
	for (int i = 1; i < 20; i++) begin
		drive_cycle(1'b1, 1'b1, random_sample());
	end
	drain_outputs(20);
	// zero history, so only the newest tap contributes
	prod = longint'(COEFF[0]) * longint'(signed'(x0));
	if (got_y.size() > got_base) begin
		compare_values("y(0)", 32'(prod[`FIR_DATA_W-1:0]), 32'(got_y[got_base]));
	end
endtask

task automatic test_impulse();
	sample_t expected;
	start_test("impulse");
	apply_reset();
	drive_cycle(1'b1, 1'b1, 18'd1);
	repeat (40) drive_cycle(1'b1, 1'b1, '0);
	drain_outputs(41);
	for (int i = 0; i < 41 && got_base + i < got_y.size(); i++) begin
		expected = (i < TAPS) ? coeff_for_tap(i) : '0;
		compare_values("impulse response", 32'(expected), 32'(got_y[got_base+i]));
	end
endtask

task automatic test_random_stream();
	start_test("random stream");
	repeat (200) drive_cycle(1'b1, 1'b1, random_sample());
	drain_outputs(200);
endtask

task automatic test_valid_gaps();
	int   n_valid;
	logic v;
	start_test("valid gaps");
	n_valid = 0;
	repeat (150) begin
		v = random_bit();
		drive_cycle(1'b1, v, random_sample());
		if (v) begin
			n_valid++;
		end
	end
	drain_outputs(n_valid);
endtask

// inputs keep changing while stalled and must be ignored
task automatic test_clk_ena_stalls();
	int   n_stall;
	int   n_valid;
	logic v;
	start_test("clock enable stalls");
	n_valid = 0;
	repeat (120) begin
		if (random_bit()) begin
			n_stall = 1 + {$random(seed)} % 5;
			repeat (n_stall) drive_cycle(1'b0, random_bit(), random_sample());
		end
		v = random_bit() | random_bit();
		drive_cycle(1'b1, v, random_sample());
		if (v) begin
			n_valid++;
		end
	end
	drain_outputs(n_valid);
endtask

task automatic test_wraparound();
	sample_t full_pos;
	sample_t full_neg;
	full_pos = {1'b0, {(`FIR_DATA_W-1){1'b1}}};
	full_neg = {1'b1, {(`FIR_DATA_W-1){1'b0}}};
	start_test("wraparound");
	repeat (40) drive_cycle(1'b1, 1'b1, random_bit() ? full_pos : full_neg);
	// a long run of the most negative value overflows every stage
	repeat (33) drive_cycle(1'b1, 1'b1, full_neg);
	drain_outputs(73);
endtask

`endif

/* bench/tb_fir.sv */
//**************************************************************************
// FIR filter testbench
// clock, reset, DUT, sample-history reference model and output checker
//**************************************************************************

`timescale 1ns/1ps

`include "fir_consts.svh"

module tb_fir
	import fir_pkg::*;
();

	localparam int TAPS          = `FIR_NUM_TAPS;
	localparam int DRAIN_TIMEOUT = 64;

	localparam logic signed [`FIR_DATA_W-1:0] COEFF [`FIR_NUM_UNIQ] = `FIR_COEFF_TABLE;

	// what the last rising edge did to the pipeline
	typedef enum {EDGE_RESET, EDGE_HELD, EDGE_TAKEN} edge_kind_t;

	logic    clk;
	logic    reset;
	logic    i_clk_ena;
	logic    i_valid;
	sample_t i_in;
	logic    o_valid;
	sample_t o_out;

	int    seed       = 32'h972b;
	int    errors     = 0;
	int    checks     = 0;
	int    valid_seen = 0;
	int    seen_base  = 0;
	int    got_base   = 0;
	string test_name  = "startup";

	// model state, newest sample in element 0
	logic signed [`FIR_DATA_W-1:0] hist [TAPS];
	logic       exp_valid_q [$];
	sample_t    exp_y_q [$];
	sample_t    got_y [$];
	edge_kind_t edge_kind = EDGE_RESET;

	logic    exp_valid;
	sample_t exp_y;
	logic    prev_valid;
	sample_t prev_out;

	fir_top uut (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_valid   (i_valid),
		.i_in      (i_in),
		.o_valid   (o_valid),
		.o_out     (o_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	`include "fir_tb_tasks.svh"

	//**********************************************************************
	// reference model
	//**********************************************************************

	// taps k and 32-k share coefficient min(k, 32-k)
	function automatic logic signed [`FIR_DATA_W-1:0] coeff_for_tap(input int k);
		int j;
		j = (k < TAPS - 1 - k) ? k : TAPS - 1 - k;
		return COEFF[j];
	endfunction

	function automatic sample_t model_output();
		longint acc;
		acc = 0;
		for (int k = 0; k < TAPS; k++) begin
			acc += longint'(coeff_for_tap(k)) * longint'(hist[k]);
		end
		// low bits of the full sum, i.e. modulo 2^18
		return acc[`FIR_DATA_W-1:0];
	endfunction

	// inputs change 1 ns after the edge, so they are stable here
	always @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < TAPS; k++) begin
				hist[k] = '0;
			end
			exp_valid_q.delete();
			exp_y_q.delete();
			edge_kind = EDGE_RESET;
		end else if (i_clk_ena) begin
			for (int k = TAPS - 1; k > 0; k--) begin
				hist[k] = hist[k-1];
			end
			hist[0] = i_in;
			exp_valid_q.push_back(i_valid);
			exp_y_q.push_back(model_output());
			edge_kind = EDGE_TAKEN;
		end else begin
			edge_kind = EDGE_HELD;
		end
	end

	//**********************************************************************
	// output checker half a cycle after each edge
	//**********************************************************************

	always @(negedge clk) begin
		if (reset || edge_kind == EDGE_RESET) begin
			compare_values("o_valid low in reset", 32'd0, 32'(o_valid));
		end else if (edge_kind == EDGE_HELD) begin
			compare_values("o_valid held in stall", 32'(prev_valid), 32'(o_valid));
			compare_values("o_out held in stall", 32'(prev_out), 32'(o_out));
		end else begin
			// the sample taken FIR_LATENCY - 1 enabled edges ago is at the output now
			if (exp_y_q.size() >= `FIR_LATENCY) begin
				exp_valid = exp_valid_q.pop_front();
				exp_y = exp_y_q.pop_front();
				compare_values("o_valid", 32'(exp_valid), 32'(o_valid));
				if (exp_valid) begin
					compare_values("o_out", 32'(exp_y), 32'(o_out));
				end
			end else begin
				// pipeline not yet filled since reset
				compare_values("o_valid before first output", 32'd0, 32'(o_valid));
			end
			if (o_valid === 1'b1) begin
				valid_seen++;
				got_y.push_back(o_out);
			end
		end
		prev_valid = o_valid;
		prev_out = o_out;
	end

	//**********************************************************************
	// test sequence
	//**********************************************************************

	initial begin
		reset = 1'b1;
		i_clk_ena = 1'b0;
		i_valid = 1'b0;
		i_in = '0;

		test_reset();
		test_impulse();
		test_random_stream();
		test_valid_gaps();
		test_clk_ena_stalls();
		test_wraparound();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+hdl
+incdir+bench
hdl/fir_pkg.sv
hdl/tap_delay_line.sv
hdl/symmetric_preadder.sv
hdl/coeff_multiplier.sv
hdl/adder_tree.sv
hdl/valid_delay.sv
hdl/fir_top.sv
bench/tb_fir.sv

/* run.sh */
#!/usr/bin/env bash
# build the FIR testbench with Verilator, run it and check the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_fir \
	--Mdir obj_dir \
	-o tb_fir_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_fir_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
